//--- logic/adc_pkg.sv
package adc_pkg;

	////////////////////////////////////////////////////////////////////
	// AD7608 frame constants
	////////////////////////////////////////////////////////////////////

	localparam int W_SAMPLE    = 18;                     // bits per adc word
	localparam int N_CHAN      = 8;                      // adc channels
	localparam int N_PER_PORT  = 4;                      // words per serial line
	localparam int RD_LENGTH   = W_SAMPLE * N_PER_PORT;  // sclk cycles per read-out
	localparam int MIN_T_CYCLE = 85;                     // min clocks in converting state
	localparam int W_OS        = 2;                      // oversampling code width
	localparam int W_CNT       = 8;                      // fsm counter width, saturating

	////////////////////////////////////////////////////////////////////
	// data types
	////////////////////////////////////////////////////////////////////

	// two's complement word as the adc shifts it out
	typedef logic signed [W_SAMPLE-1:0] sample_t;

	typedef logic [$clog2(N_CHAN)-1:0] chan_t;      // channel 0..7
	typedef logic [$clog2(N_PER_PORT)-1:0] slot_t;  // word position on one line

endpackage

//--- logic/sample_bus_if.sv
interface sample_bus_if;
	import adc_pkg::*;

	logic    req;    // access request, held until gnt
	logic    we;     // 1 = write, 0 = read
	chan_t   addr;   // store slot
	sample_t wdata;  // write word
	logic    gnt;    // one-cycle grant, access happens here
	sample_t rdata;  // read word, one cycle after gnt
	logic    rvalid; // qualifies rdata

	// port that issues accesses
	modport requester (
		output req, we, addr, wdata,
		input  gnt, rdata, rvalid
	);

	// port that serves accesses
	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata, rvalid
	);

endinterface

//--- logic/adc_conversion_engine.sv
module adc_conversion_engine (
	input  logic             clk_in,
	input  logic             reset_in,
	input  logic             busy,        // conversion in progress
	input  logic             data_a,      // serial line a, ch 0-3
	input  logic             data_b,      // serial line b, ch 4-7
	input  logic             cstart,      // starts continuous conversion
	output logic             convst_out,  // active low convert start
	output logic             n_cs_out,    // active low chip select
	output logic             sclk_out,    // serial clock, high when idle
	output logic             word_valid,  // one word per line complete
	output adc_pkg::slot_t   word_slot,   // which word just completed
	output adc_pkg::sample_t word_a,
	output adc_pkg::sample_t word_b
);
	import adc_pkg::*;

	typedef enum logic [1:0] {CV_IDLE, CV_CONVST, CV_CONV} cv_state_t;
	typedef enum logic [1:0] {RD_IDLE, RD_READ, RD_WAIT} rd_state_t;

	cv_state_t cv_state;             // convert fsm
	cv_state_t cv_next;
	logic [W_CNT-1:0] cv_count;      // clocks in current cv state
	rd_state_t rd_state;             // read fsm
	rd_state_t rd_next;
	logic [W_CNT-1:0] rd_count;      // clocks in current rd state
	logic [W_SAMPLE-1:0] shift_a;    // line a shift register
	logic [W_SAMPLE-1:0] shift_b;    // line b shift register
	logic sclk_en;                   // clock gate, updated on falling edge

	// conversions and read-outs overlap, so the two fsms never wait on each other

	////////////////////////////////////////////////////////////////////
	// convert state machine
	////////////////////////////////////////////////////////////////////

	always_comb begin
		cv_next = cv_state;                                    // hold by default
		case (cv_state)
			CV_IDLE:   if (cstart) cv_next = CV_CONVST;
			CV_CONVST: cv_next = CV_CONV;                      // single low cycle
			CV_CONV: begin
				if (cv_count >= W_CNT'(MIN_T_CYCLE) && !busy) // min cycle time met
					cv_next = CV_CONVST;
			end
			default:   cv_next = CV_IDLE;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			cv_state <= CV_IDLE;
			cv_count <= '0;
		end else begin
			cv_state <= cv_next;
			if (cv_next != cv_state)
				cv_count <= '0;                                // restart on change
			else if (cv_count != '1)
				cv_count <= cv_count + 1'b1;                   // saturate, no wrap
		end
	end

	assign convst_out = (cv_state != CV_CONVST);

	////////////////////////////////////////////////////////////////////
	// read state machine
	////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			RD_IDLE: if (busy) rd_next = RD_READ;                    // new conversion
			RD_READ: if (rd_count == W_CNT'(RD_LENGTH)) rd_next = RD_WAIT;
			RD_WAIT: if (!busy) rd_next = RD_IDLE;                   // let it finish
			default: rd_next = RD_IDLE;
		endcase
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			rd_state <= RD_IDLE;
			rd_count <= '0;
		end else begin
			rd_state <= rd_next;
			if (rd_next != rd_state)
				rd_count <= '0;
			else if (rd_count != '1)
				rd_count <= rd_count + 1'b1;
		end
	end

	// low for counts 0..RD_LENGTH-1 only
	assign n_cs_out = !(rd_state == RD_READ && rd_count < W_CNT'(RD_LENGTH));

	////////////////////////////////////////////////////////////////////
	// serial data path
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (!n_cs_out) begin
			shift_a <= {shift_a[W_SAMPLE-2:0], data_a};        // msb first
			shift_b <= {shift_b[W_SAMPLE-2:0], data_b};
		end
	end

	// word k complete once 18*(k+1) bits are in
	always_comb begin
		word_valid = 1'b0;
		word_slot  = '0;
		for (int k = 0; k < N_PER_PORT; k++) begin
			if (rd_state == RD_READ && rd_count == W_CNT'(W_SAMPLE * (k + 1))) begin
				word_valid = 1'b1;
				word_slot  = slot_t'(k);
			end
		end
	end

	assign word_a = sample_t'(shift_a);
	assign word_b = sample_t'(shift_b);

	// enable changes while clk_in is low, so sclk_out has no runt pulse
	always_ff @(negedge clk_in) begin
		if (reset_in)
			sclk_en <= 1'b0;
		else
			sclk_en <= !n_cs_out;
	end

	assign sclk_out = sclk_en ? clk_in : 1'b1;              // parked high when deselected

endmodule

//--- logic/sample_writer.sv
module sample_writer (
	input  logic               clk_in,
	input  logic               reset_in,
	input  logic               word_valid,  // word pair ready
	input  adc_pkg::slot_t     word_slot,
	input  adc_pkg::sample_t   word_a,      // goes to channel word_slot
	input  adc_pkg::sample_t   word_b,      // goes to channel word_slot+4
	sample_bus_if.requester    bus,
	output logic               frame_done   // all eight channels stored
);
	import adc_pkg::*;

	logic    pend_a;      // line a write outstanding
	logic    pend_b;      // line b write outstanding
	slot_t   slot_q;
	sample_t word_a_q;
	sample_t word_b_q;
	logic    last_grant;  // final write of the frame granted

	////////////////////////////////////////////////////////////////////
	// word pair buffer
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (word_valid) begin
			slot_q   <= word_slot;
			word_a_q <= word_a;
			word_b_q <= word_b;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			pend_a     <= 1'b0;
			pend_b     <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			if (word_valid) begin
				pend_a <= 1'b1;
				pend_b <= 1'b1;
			end else if (bus.gnt) begin
				if (pend_a)
					pend_a <= 1'b0;   // line a goes first
				else
					pend_b <= 1'b0;
			end
			frame_done <= last_grant;
		end
	end

	assign last_grant = bus.gnt && !pend_a && pend_b && slot_q == slot_t'(N_PER_PORT - 1);

	// request held stable until granted
	assign bus.req   = pend_a | pend_b;
	assign bus.we    = 1'b1;
	assign bus.addr  = pend_a ? chan_t'(slot_q) : chan_t'(slot_q) + chan_t'(N_PER_PORT);
	assign bus.wdata = pend_a ? word_a_q : word_b_q;

endmodule

//--- logic/sample_store.sv
module sample_store (
	input  logic            clk_in,
	input  logic            reset_in,
	sample_bus_if.arbiter   wr_bus,    // high priority port
	sample_bus_if.arbiter   rd_bus     // low priority port
);
	import adc_pkg::*;

	sample_t mem [N_CHAN];  // latest word per channel
	logic    acc_valid;     // an access happens this cycle
	logic    acc_we;
	chan_t   acc_addr;
	sample_t acc_wdata;
	sample_t rdata_q;       // shared read register
	logic    wr_rvalid;
	logic    rd_rvalid;

	////////////////////////////////////////////////////////////////////
	// fixed-priority arbiter
	////////////////////////////////////////////////////////////////////

	assign wr_bus.gnt = wr_bus.req;                  // writer always wins
	assign rd_bus.gnt = rd_bus.req & ~wr_bus.req;    // host waits its turn

	assign acc_valid = wr_bus.req | rd_bus.req;

	always_comb begin
		if (wr_bus.req) begin
			acc_we    = wr_bus.we;
			acc_addr  = wr_bus.addr;
			acc_wdata = wr_bus.wdata;
		end else begin
			acc_we    = rd_bus.we;
			acc_addr  = rd_bus.addr;
			acc_wdata = rd_bus.wdata;
		end
	end

	////////////////////////////////////////////////////////////////////
	// memory
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			for (int i = 0; i < N_CHAN; i++)
				mem[i] <= '0;                    // reads before first frame give zero
		end else if (acc_valid && acc_we) begin
			mem[acc_addr] <= acc_wdata;
		end
	end

	always_ff @(posedge clk_in) begin
		if (acc_valid && !acc_we)
			rdata_q <= mem[acc_addr];
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			wr_rvalid <= 1'b0;
			rd_rvalid <= 1'b0;
		end else begin
			wr_rvalid <= wr_bus.gnt & ~wr_bus.we;  // rvalid back to the granted port
			rd_rvalid <= rd_bus.gnt & ~rd_bus.we;
		end
	end

	assign wr_bus.rdata  = rdata_q;
	assign rd_bus.rdata  = rdata_q;
	assign wr_bus.rvalid = wr_rvalid;
	assign rd_bus.rvalid = rd_rvalid;

endmodule

//--- logic/host_read_port.sv
module host_read_port (
	input  logic               clk_in,
	input  logic               reset_in,
	input  logic               rd_req,    // one-cycle read pulse
	input  adc_pkg::chan_t     rd_chan,
	output adc_pkg::sample_t   rd_data,
	output logic               rd_valid,  // qualifies rd_data
	sample_bus_if.requester    bus
);
	import adc_pkg::*;

	logic  pending;  // request waiting for grant
	chan_t chan_q;
	logic  accept;   // take a new host request

	// a new request is only taken once the old one is off the bus
	assign accept = rd_req & (~pending | bus.gnt);

	always_ff @(posedge clk_in) begin
		if (reset_in)
			pending <= 1'b0;
		else if (accept)
			pending <= 1'b1;
		else if (bus.gnt)
			pending <= 1'b0;
	end

	always_ff @(posedge clk_in) begin
		if (accept)
			chan_q <= rd_chan;
	end

	assign bus.req   = pending;
	assign bus.we    = 1'b0;   // read only port
	assign bus.addr  = chan_q;
	assign bus.wdata = '0;

	// store registers the word, one cycle after grant
	assign rd_data  = bus.rdata;
	assign rd_valid = bus.rvalid;

endmodule

//--- logic/adc_sampler.sv
module adc_sampler (
	input  logic                      clk_in,
	input  logic                      reset_in,
	input  logic                      busy_in,     // adc busy
	input  logic                      data_a_in,   // adc dout a
	input  logic                      data_b_in,   // adc dout b
	input  logic [adc_pkg::W_OS-1:0]  os_in,       // oversampling code
	input  logic                      cstart,      // start continuous conversion
	output logic [adc_pkg::W_OS-1:0]  os_out,
	output logic                      convst_out,
	output logic                      reset_out,
	output logic                      sclk_out,
	output logic                      n_cs_out,
	input  logic                      rd_req,      // host read pulse
	input  adc_pkg::chan_t            rd_chan,
	output adc_pkg::sample_t          rd_data,
	output logic                      rd_valid,
	output logic                      frame_done   // one conversion fully stored
);
	import adc_pkg::*;

	logic    word_valid;
	slot_t   word_slot;
	sample_t word_a;
	sample_t word_b;

	sample_bus_if wr_bus ();  // writer to store
	sample_bus_if rd_bus ();  // host port to store

	////////////////////////////////////////////////////////////////////
	// adc pins
	////////////////////////////////////////////////////////////////////

	assign os_out    = os_in;
	assign reset_out = reset_in;

	adc_conversion_engine u_engine (
		.clk_in, .reset_in,
		.busy       (busy_in),
		.data_a     (data_a_in),
		.data_b     (data_b_in),
		.cstart,
		.convst_out, .n_cs_out, .sclk_out,
		.word_valid, .word_slot, .word_a, .word_b
	);

	sample_writer u_writer (
		.clk_in, .reset_in,
		.word_valid, .word_slot, .word_a, .word_b,
		.bus        (wr_bus.requester),
		.frame_done
	);

	sample_store u_store (
		.clk_in, .reset_in,
		.wr_bus     (wr_bus.arbiter),
		.rd_bus     (rd_bus.arbiter)
	);

	host_read_port u_host (
		.clk_in, .reset_in,
		.rd_req, .rd_chan, .rd_data, .rd_valid,
		.bus        (rd_bus.requester)
	);

endmodule

//--- tests/adc_model.sv
module adc_model (
	input  logic clk_in,
	input  logic convst,   // active low, from the dut
	input  logic n_cs,     // active low chip select
	output logic busy,
	output logic data_a,   // channels 0-3
	output logic data_b    // channels 4-7
);
	timeunit 1ns;
	timeprecision 1ps;
	import adc_pkg::*;

	localparam int T_BUSY = 120;      // clocks of busy per conversion

	sample_t     next_set [N_CHAN];   // loaded when busy falls
	sample_t     shown [N_CHAN];      // set of the current or last read-out
	sample_t     shown_prev [N_CHAN]; // set of the read-out before that
	int          bit_idx = 0;         // position in the 72-bit read-out
	int          word_i;
	int          bit_i;
	logic        bit_a = 1'b0;
	logic        bit_b = 1'b0;
	int unsigned seed = 3;

	assign data_a = bit_a;
	assign data_b = bit_b;

	//////////////////////////////////////////////////////////////////////
	// conversion
	//////////////////////////////////////////////////////////////////////

	initial begin
		busy = 1'b0;
		void'($urandom(seed));                                  // one seed per run
		for (int c = 0; c < N_CHAN; c++)
			next_set[c] = sample_t'(18'h2A5A5 + c * 18'h0B3C7);  // mixed signs
		forever begin
			@(negedge convst);
			@(negedge clk_in);
			busy = 1'b1;
			repeat (T_BUSY) @(negedge clk_in);
			busy = 1'b0;
			for (int c = 0; c < N_CHAN; c++)
				next_set[c] = sample_t'($urandom);
			next_set[N_CHAN-1][W_SAMPLE-1] = 1'b1;               // force one negative word
		end
	end

	// the set goes on the lines when chip select falls
	initial begin
		for (int c = 0; c < N_CHAN; c++) begin
			shown[c]      = '0;
			shown_prev[c] = '0;                                  // matches a cleared store
		end
		forever begin
			@(negedge n_cs);
			for (int c = 0; c < N_CHAN; c++) begin
				shown_prev[c] = shown[c];
				shown[c]      = next_set[c];
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// serial lines
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_in) begin
		word_i = bit_idx / W_SAMPLE;                   // slot on each line
		bit_i  = W_SAMPLE - 1 - bit_idx % W_SAMPLE;   // msb first
		if (!n_cs) begin
			bit_a   <= shown[word_i][bit_i];
			bit_b   <= shown[N_PER_PORT + word_i][bit_i];
			bit_idx <= bit_idx + 1;
		end else begin
			bit_idx <= 0;
		end
	end

endmodule

//--- tests/adc_sampler_tb.sv
module adc_sampler_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import adc_pkg::*;

	localparam int FRAME_CYCLES = 210;                       // generous per conversion
	localparam int MAX_CYCLES   = 6 * FRAME_CYCLES + 1000;
	localparam int N_FRAMES     = 5;

	logic            clk_in;
	logic            reset_in;
	logic            busy_in;
	logic            data_a_in;
	logic            data_b_in;
	logic [W_OS-1:0] os_in;
	logic            cstart;
	logic [W_OS-1:0] os_out;
	logic            convst_out;
	logic            reset_out;
	logic            sclk_out;
	logic            n_cs_out;
	logic            rd_req;
	chan_t           rd_chan;
	sample_t         rd_data;
	logic            rd_valid;
	logic            frame_done;

	int cycles      = 0;
	int checks      = 0;
	int errors      = 0;
	int frames      = 0;   // frame_done pulses
	int req_count   = 0;   // rd_req pulses
	int valid_count = 0;   // rd_valid pulses

	adc_sampler dut (.*);

	adc_model model (
		.clk_in,
		.convst (convst_out),
		.n_cs   (n_cs_out),
		.busy   (busy_in),
		.data_a (data_a_in),
		.data_b (data_b_in)
	);

	initial begin
		clk_in = 1'b0;
		forever #4 clk_in = ~clk_in;   // 8 ns period
	end

	// event counters sampled mid cycle
	always @(negedge clk_in) begin
		cycles++;
		if (frame_done) frames++;
		if (rd_req) req_count++;
		if (rd_valid) valid_count++;
		if (cycles == MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	task automatic tick();
		@(posedge clk_in);
		#1;                  // drive and sample after the edge
	endtask

	task automatic compare(input int got, input int exp, input string what);
		checks++;
		assert (got == exp)
		else begin
			errors++;
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic verify(input bit ok, input string what);
		checks++;
		assert (ok)
		else begin
			errors++;
			$display("Error at %0t: %s", $time, what);
		end
	endtask

	task automatic expect_idle();
		compare(convst_out, 1, "convst_out");
		compare(n_cs_out, 1, "n_cs_out");
		compare(frame_done, 0, "frame_done");
		compare(rd_valid, 0, "rd_valid");
	endtask

	task automatic read_channel(input chan_t ch, output sample_t data);
		rd_req  = 1'b1;
		rd_chan = ch;
		tick();
		rd_req = 1'b0;
		while (!rd_valid)
			tick();            // waits out writer grants
		data = rd_data;
	endtask

	task automatic wait_frame();
		int start;
		start = frames;
		while (frames == start)
			tick();
	endtask

	//////////////////////////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////////////////////////

	task automatic reset_state_test();
		sample_t data;
		for (int i = 0; i < 6; i++) begin
			tick();
			compare(reset_out, i < 2, "reset_out");
			expect_idle();
			if (i == 1)
				reset_in = 1'b0;                         // two reset edges seen
			#4;                                          // low clock phase
			compare(sclk_out, 1, "sclk_out in low phase");
		end
		tick();
		for (int c = 0; c < N_CHAN; c++) begin
			read_channel(chan_t'(c), data);
			compare(data, 0, $sformatf("rd_data ch%0d after reset", c));
		end
	endtask

	task automatic convert_timing_test();
		int   last_conv;
		int   n_conv;
		int   low_run;
		int   windows;
		logic busy_q;
		cstart = 1'b1;
		tick();
		cstart = 1'b0;
		compare(convst_out, 0, "convst_out after cstart");
		last_conv = cycles;
		n_conv    = 1;
		low_run   = 0;
		windows   = 0;
		busy_q    = busy_in;
		while (n_conv < 3) begin
			tick();
			if (!convst_out) begin
				verify(cycles - last_conv >= MIN_T_CYCLE + 1, "convst pulse came too soon");
				verify(!busy_in, "convst pulsed while busy was high");
				last_conv = cycles;
				n_conv++;
			end
			if (busy_in && !busy_q)
				compare(n_cs_out, 0, "n_cs_out when busy is seen");
			if (!n_cs_out) begin
				low_run++;
			end else if (low_run != 0) begin
				compare(low_run, RD_LENGTH, "n_cs_out low cycles");
				low_run = 0;
				windows++;
			end
			busy_q = busy_in;
			#4;                                          // low clock phase
			compare(sclk_out, n_cs_out, "sclk_out in low phase");
		end
		compare(windows, 2, "read-out windows");
	endtask

	task automatic data_integrity_test();
		sample_t data;
		for (int f = 0; f < N_FRAMES; f++) begin
			wait_frame();
			for (int c = 0; c < N_CHAN; c++) begin
				read_channel(chan_t'(c), data);
				compare(data, model.shown[c], $sformatf("frame %0d ch%0d", f, c));
			end
		end
	endtask

	task automatic arbitration_test();
		sample_t data;
		int      start;
		int      n;
		chan_t   ch;
		while (n_cs_out)
			tick();                                      // read-out begins
		start = frames;
		n     = 0;
		while (frames == start) begin
			ch = chan_t'(n);                             // wraps over the channels
			read_channel(ch, data);
			checks++;
			assert (data == model.shown[ch] || data == model.shown_prev[ch])
			else begin
				errors++;
				$display("Mismatch at %0t: ch%0d gave %0d, expected %0d or %0d", $time, ch,
					data, model.shown_prev[ch], model.shown[ch]);
			end
			n++;
		end
		tick();
		tick();
		compare(valid_count, req_count, "rd_valid pulses per rd_req");
		for (int c = 0; c < N_CHAN; c++) begin
			read_channel(chan_t'(c), data);
			compare(data, model.shown[c], $sformatf("ch%0d after frame_done", c));
		end
	endtask

	task automatic pass_through_test();
		for (int code = 0; code < 2 ** W_OS; code++) begin
			os_in = W_OS'(code);
			#1;
			compare(os_out, code, "os_out");
			tick();
		end
		reset_in = 1'b1;
		#1;
		compare(reset_out, 1, "reset_out high");
		tick();
		reset_in = 1'b0;
		#1;
		compare(reset_out, 0, "reset_out low");
	endtask

	initial begin
		reset_in = 1'b1;
		cstart   = 1'b0;
		rd_req   = 1'b0;
		rd_chan  = '0;
		os_in    = '0;
		reset_state_test();
		convert_timing_test();
		data_integrity_test();
		arbitration_test();
		pass_through_test();
		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- adc_sampler.f
logic/adc_pkg.sv
logic/sample_bus_if.sv
logic/adc_conversion_engine.sv
logic/sample_writer.sv
logic/sample_store.sv
logic/host_read_port.sv
logic/adc_sampler.sv
tests/adc_model.sv
tests/adc_sampler_tb.sv

//--- Bender.yml
package:
  name: adc_sampler

sources:
  - logic/adc_pkg.sv
  - logic/sample_bus_if.sv
  - logic/adc_conversion_engine.sv
  - logic/sample_writer.sv
  - logic/sample_store.sv
  - logic/host_read_port.sv
  - logic/adc_sampler.sv
  - target: test
    files:
      - tests/adc_model.sv
      - tests/adc_sampler_tb.sv
